// File: design/dcache_pkg.sv
// Widths, vector types and controller states shared by every unit of the L1 data cache
`default_nettype none

package dcache_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int BEAT_W = 64;

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [BEAT_W-1:0]   beat_t;
	// One enable bit per byte of a word
	typedef logic [WORD_W/8-1:0] mask_t;

	// Request sequencing in the controller
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL_REQ,
		REFILL_GET,
		REFILL_OUT,
		WR_REQ,
		IO_WAIT
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dcache_way_if.sv
// Lookup, fill and write-update signals driven by the cache controller into all ways
`timescale 1ns/1ps
`default_nettype none

interface dcache_way_if #(
	parameter int NUM_WAYS   = 4,
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 8
) ();
	import dcache_pkg::*;

	localparam int IDX_W  = $clog2(NUM_SETS);
	localparam int BIDX_W = $clog2(LINE_BEATS);
	localparam int WSEL_W = $clog2(BEAT_W / WORD_W);
	localparam int WOFF_W = BIDX_W + WSEL_W;
	localparam int OFF_W  = WOFF_W + $clog2(WORD_W / 8);
	localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;

	// Lookup of the registered request
	logic [IDX_W-1:0]    lookup_index;
	logic [TAG_W-1:0]    lookup_tag;
	// Word index inside the line
	logic [WOFF_W-1:0]   lookup_offset;

	// Refill beats into the chosen way
	logic                fill_en;
	logic [NUM_WAYS-1:0] fill_way;
	logic [BIDX_W-1:0]   fill_beat_idx;
	beat_t               fill_beat;

	// Write-through update of a hitting line
	logic                upd_en;
	mask_t               upd_mask;
	word_t               upd_data;

	modport ctrl (
		output lookup_index, lookup_tag, lookup_offset,
		output fill_en, fill_way, fill_beat_idx, fill_beat,
		output upd_en, upd_mask, upd_data
	);

	modport way (
		input lookup_index, lookup_tag, lookup_offset,
		input fill_en, fill_beat_idx, fill_beat,
		input upd_en, upd_mask, upd_data
	);

endinterface

`default_nettype wire

// File: design/dcache_way.sv
// One cache way with valid bits, tags and line storage, instanced once per way by the top level
`timescale 1ns/1ps
`default_nettype none

module dcache_way #(
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 8
) (
	input  logic              iCLOCK,
	input  logic              inRESET,
	dcache_way_if.way         way_bus,
	input  logic              way_id_hot,
	output logic              hit,
	output logic              line_valid,
	output dcache_pkg::word_t word
);
	import dcache_pkg::*;

	localparam int IDX_W  = $clog2(NUM_SETS);
	localparam int BIDX_W = $clog2(LINE_BEATS);
	localparam int WSEL_W = $clog2(BEAT_W / WORD_W);
	localparam int WOFF_W = BIDX_W + WSEL_W;
	localparam int OFF_W  = WOFF_W + $clog2(WORD_W / 8);
	localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;

	logic [NUM_SETS-1:0] valid_q;
	logic [TAG_W-1:0]    tag_q [NUM_SETS];
	beat_t               data_q [NUM_SETS][LINE_BEATS];

	logic [IDX_W-1:0]    idx;
	logic [BIDX_W-1:0]   rd_beat;
	logic [WSEL_W-1:0]   rd_wsel;
	logic                fill_sel;
	logic                fill_last;
	logic                upd_hit;

	assign idx       = way_bus.lookup_index;
	assign rd_beat   = way_bus.lookup_offset[WOFF_W-1 -: BIDX_W];
	assign rd_wsel   = way_bus.lookup_offset[WSEL_W-1:0];
	assign fill_sel  = way_bus.fill_en && way_id_hot;
	assign fill_last = (way_bus.fill_beat_idx == BIDX_W'(LINE_BEATS - 1));

	assign line_valid = valid_q[idx];
	assign hit        = valid_q[idx] && (tag_q[idx] == way_bus.lookup_tag);
	assign word       = data_q[idx][rd_beat][rd_wsel*WORD_W +: WORD_W];
	assign upd_hit    = way_bus.upd_en && hit;

	// Line drops out while its beats are replaced and returns with the last one
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end else if (fill_sel) begin
			valid_q[idx] <= fill_last;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (fill_sel && fill_last) begin
			tag_q[idx] <= way_bus.lookup_tag;
		end
	end

	// Refill beats, or byte lanes of a write that hits
	always_ff @(posedge iCLOCK) begin
		if (fill_sel) begin
			data_q[idx][way_bus.fill_beat_idx] <= way_bus.fill_beat;
		end else if (upd_hit) begin
			for (int b = 0; b < WORD_W / 8; b++) begin
				if (way_bus.upd_mask[b]) begin
					data_q[idx][rd_beat][rd_wsel*WORD_W + b*8 +: 8] <= way_bus.upd_data[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/dcache_way_select.sv
// Merges the per-way lookup results and picks the refill victim for the cache controller
`timescale 1ns/1ps
`default_nettype none

module dcache_way_select #(
	parameter int NUM_WAYS = 4
) (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic [NUM_WAYS-1:0] way_hit,
	input  logic [NUM_WAYS-1:0] way_valid,
	input  dcache_pkg::word_t   way_word [NUM_WAYS],
	output logic                hit,
	output dcache_pkg::word_t   hit_word,
	output logic [NUM_WAYS-1:0] victim
);

	logic [NUM_WAYS-1:0] rr_q;
	logic [NUM_WAYS-1:0] valid_prev_q;
	logic [NUM_WAYS-1:0] first_free;
	logic                refill_done;

	assign hit = |way_hit;

	// At most one way hits, so an OR of the gated words is enough
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (way_hit[i]) begin
				hit_word = hit_word | way_word[i];
			end
		end
	end

	// Lowest clear bit of the valid vector
	assign first_free = ~way_valid & (way_valid + 1'b1);
	assign victim     = (|first_free) ? first_free : rr_q;

	// A completed refill shows as a line turning valid and hitting
	assign refill_done = |(way_valid & ~valid_prev_q & way_hit);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rr_q         <= NUM_WAYS'(1);
			valid_prev_q <= '0;
		end else begin
			valid_prev_q <= way_valid;
			if (refill_done) begin
				rr_q <= (rr_q << 1) | (rr_q >> (NUM_WAYS - 1));
			end
		end
	end

	// Tags in one set never repeat across ways
	a_single_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0(way_hit))
		else $error("more than one way hits");

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
// Request controller of the L1 data cache with IO routing, refill and write-through
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int NUM_WAYS   = 4,
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 8
) (
	input  logic                iCLOCK,
	input  logic                inRESET,
	// IO base
	input  logic                iosr_valid,
	input  dcache_pkg::addr_t   iosr,
	// Load/store side
	input  logic                ldst_req_valid,
	output logic                ldst_req_ready,
	input  logic                ldst_rw,
	input  dcache_pkg::mask_t   ldst_mask,
	input  dcache_pkg::addr_t   ldst_addr,
	input  dcache_pkg::word_t   ldst_data,
	output logic                ldst_rsp_valid,
	output dcache_pkg::word_t   ldst_rsp_data,
	// Memory port
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output logic                mem_req_rw,
	output dcache_pkg::addr_t   mem_req_addr,
	output dcache_pkg::mask_t   mem_req_mask,
	output dcache_pkg::word_t   mem_req_data,
	input  logic                mem_rsp_valid,
	input  dcache_pkg::beat_t   mem_rsp_data,
	// IO port
	output logic                io_req_valid,
	input  logic                io_req_ready,
	output logic                io_req_rw,
	output dcache_pkg::addr_t   io_req_addr,
	output dcache_pkg::mask_t   io_req_mask,
	output dcache_pkg::word_t   io_req_data,
	input  logic                io_rsp_valid,
	input  dcache_pkg::word_t   io_rsp_data,
	// Way results
	input  logic                hit,
	input  dcache_pkg::word_t   hit_word,
	input  logic [NUM_WAYS-1:0] victim,
	dcache_way_if.ctrl          way_bus
);
	import dcache_pkg::*;

	localparam int IDX_W  = $clog2(NUM_SETS);
	localparam int BIDX_W = $clog2(LINE_BEATS);
	localparam int WSEL_W = $clog2(BEAT_W / WORD_W);
	localparam int BSEL_W = $clog2(WORD_W / 8);
	localparam int WOFF_W = BIDX_W + WSEL_W;
	localparam int OFF_W  = WOFF_W + BSEL_W;
	localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;

	ctrl_state_t         state_q;
	logic                base_valid_q;
	addr_t               io_base_q;
	logic                req_rw_q;
	mask_t               req_mask_q;
	addr_t               req_addr_q;
	word_t               req_data_q;
	logic [NUM_WAYS-1:0] fill_way_q;
	logic [BIDX_W-1:0]   beat_cnt_q;
	logic                io_pend_q;
	word_t               rsp_word_q;

	logic                req_fire;
	logic                to_io;
	logic                last_beat;
	logic [BIDX_W-1:0]   req_beat;
	logic [WSEL_W-1:0]   req_wsel;

	assign req_fire  = ldst_req_valid && ldst_req_ready;
	assign to_io     = (ldst_addr >= io_base_q);
	assign last_beat = (beat_cnt_q == BIDX_W'(LINE_BEATS - 1));
	assign req_beat  = req_addr_q[OFF_W-1 -: BIDX_W];
	assign req_wsel  = req_addr_q[BSEL_W +: WSEL_W];

	// IO base, requests are refused until it is loaded
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			base_valid_q <= 1'b0;
		end else if (iosr_valid) begin
			base_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (iosr_valid) begin
			io_base_q <= iosr;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (req_fire) begin
			req_rw_q   <= ldst_rw;
			req_mask_q <= ldst_mask;
			req_addr_q <= ldst_addr;
			req_data_q <= ldst_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q    <= IDLE;
			fill_way_q <= '0;
			beat_cnt_q <= '0;
			io_pend_q  <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (req_fire) begin
						if (to_io) begin
							state_q   <= IO_WAIT;
							io_pend_q <= 1'b1;
						end else if (ldst_rw) begin
							state_q <= LOOKUP;
						end else begin
							state_q <= WR_REQ;
						end
					end
				end
				LOOKUP: begin
					if (hit) begin
						state_q <= IDLE;
					end else begin
						state_q    <= REFILL_REQ;
						fill_way_q <= victim;
					end
				end
				REFILL_REQ: begin
					if (mem_req_ready) begin
						state_q    <= REFILL_GET;
						beat_cnt_q <= '0;
					end
				end
				REFILL_GET: begin
					if (mem_rsp_valid) begin
						beat_cnt_q <= beat_cnt_q + 1'b1;
						if (last_beat) begin
							state_q <= REFILL_OUT;
						end
					end
				end
				// Response cycle for refills and memory writes alike
				REFILL_OUT: state_q <= IDLE;
				WR_REQ: begin
					if (mem_req_ready) begin
						state_q <= REFILL_OUT;
					end
				end
				IO_WAIT: begin
					if (io_pend_q) begin
						if (io_req_ready) begin
							io_pend_q <= 1'b0;
						end
					end else if (io_rsp_valid) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Requested word out of its beat
	always_ff @(posedge iCLOCK) begin
		if (state_q == REFILL_GET && mem_rsp_valid && beat_cnt_q == req_beat) begin
			rsp_word_q <= mem_rsp_data[req_wsel*WORD_W +: WORD_W];
		end
	end

	assign ldst_req_ready = (state_q == IDLE) && base_valid_q;
	assign ldst_rsp_valid = (state_q == LOOKUP && hit) || (state_q == REFILL_OUT)
		|| (state_q == IO_WAIT && !io_pend_q && io_rsp_valid);

	always_comb begin
		case (state_q)
			LOOKUP:  ldst_rsp_data = hit_word;
			IO_WAIT: ldst_rsp_data = io_rsp_data;
			default: ldst_rsp_data = rsp_word_q;
		endcase
	end

	// Line-aligned address for a refill, the exact one for a write
	assign mem_req_valid = (state_q == REFILL_REQ) || (state_q == WR_REQ);
	assign mem_req_rw    = (state_q == REFILL_REQ);
	assign mem_req_addr  = (state_q == REFILL_REQ) ?
		{req_addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}} : req_addr_q;
	assign mem_req_mask  = req_mask_q;
	assign mem_req_data  = req_data_q;

	assign io_req_valid = io_pend_q;
	assign io_req_rw    = req_rw_q;
	assign io_req_addr  = req_addr_q - io_base_q;
	assign io_req_mask  = req_mask_q;
	assign io_req_data  = req_data_q;

	assign way_bus.lookup_index  = req_addr_q[OFF_W +: IDX_W];
	assign way_bus.lookup_tag    = req_addr_q[ADDR_W-1 -: TAG_W];
	assign way_bus.lookup_offset = req_addr_q[BSEL_W +: WOFF_W];
	assign way_bus.fill_en       = (state_q == REFILL_GET) && mem_rsp_valid;
	assign way_bus.fill_way      = fill_way_q;
	assign way_bus.fill_beat_idx = beat_cnt_q;
	assign way_bus.fill_beat     = mem_rsp_data;
	assign way_bus.upd_en        = (state_q == WR_REQ);
	assign way_bus.upd_mask      = req_mask_q;
	assign way_bus.upd_data      = req_data_q;

	a_port_excl: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(mem_req_valid && io_req_valid))
		else $error("memory and IO requests raised together");

	// Held request keeps its fields until the transfer
	a_mem_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_rw)
		&& $stable(mem_req_addr) && $stable(mem_req_mask) && $stable(mem_req_data))
		else $error("memory request changed while waiting for ready");

endmodule

`default_nettype wire

// File: design/dcache_top.sv
// Top level of the L1 data cache that connects the controller, the ways and the way selector
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int NUM_WAYS   = 4,
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 8
) (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              iosr_valid,
	input  dcache_pkg::addr_t iosr,
	input  logic              ldst_req_valid,
	output logic              ldst_req_ready,
	input  logic              ldst_rw,
	input  dcache_pkg::mask_t ldst_mask,
	input  dcache_pkg::addr_t ldst_addr,
	input  dcache_pkg::word_t ldst_data,
	output logic              ldst_rsp_valid,
	output dcache_pkg::word_t ldst_rsp_data,
	output logic              mem_req_valid,
	input  logic              mem_req_ready,
	output logic              mem_req_rw,
	output dcache_pkg::addr_t mem_req_addr,
	output dcache_pkg::mask_t mem_req_mask,
	output dcache_pkg::word_t mem_req_data,
	input  logic              mem_rsp_valid,
	input  dcache_pkg::beat_t mem_rsp_data,
	output logic              io_req_valid,
	input  logic              io_req_ready,
	output logic              io_req_rw,
	output dcache_pkg::addr_t io_req_addr,
	output dcache_pkg::mask_t io_req_mask,
	output dcache_pkg::word_t io_req_data,
	input  logic              io_rsp_valid,
	input  dcache_pkg::word_t io_rsp_data
);
	import dcache_pkg::*;

	dcache_way_if #(
		.NUM_WAYS   (NUM_WAYS),
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) way_bus ();

	// Per-way results
	logic [NUM_WAYS-1:0] way_hit;
	logic [NUM_WAYS-1:0] way_valid;
	word_t               way_word [NUM_WAYS];

	logic                sel_hit;
	word_t               sel_word;
	logic [NUM_WAYS-1:0] sel_victim;

	dcache_ctrl #(
		.NUM_WAYS   (NUM_WAYS),
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) u_ctrl (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.iosr_valid     (iosr_valid),
		.iosr           (iosr),
		.ldst_req_valid (ldst_req_valid),
		.ldst_req_ready (ldst_req_ready),
		.ldst_rw        (ldst_rw),
		.ldst_mask      (ldst_mask),
		.ldst_addr      (ldst_addr),
		.ldst_data      (ldst_data),
		.ldst_rsp_valid (ldst_rsp_valid),
		.ldst_rsp_data  (ldst_rsp_data),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_rw     (mem_req_rw),
		.mem_req_addr   (mem_req_addr),
		.mem_req_mask   (mem_req_mask),
		.mem_req_data   (mem_req_data),
		.mem_rsp_valid  (mem_rsp_valid),
		.mem_rsp_data   (mem_rsp_data),
		.io_req_valid   (io_req_valid),
		.io_req_ready   (io_req_ready),
		.io_req_rw      (io_req_rw),
		.io_req_addr    (io_req_addr),
		.io_req_mask    (io_req_mask),
		.io_req_data    (io_req_data),
		.io_rsp_valid   (io_rsp_valid),
		.io_rsp_data    (io_rsp_data),
		.hit            (sel_hit),
		.hit_word       (sel_word),
		.victim         (sel_victim),
		.way_bus        (way_bus)
	);

	// Each way takes its own bit of the fill select
	for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
		dcache_way #(
			.NUM_SETS   (NUM_SETS),
			.LINE_BEATS (LINE_BEATS)
		) u_way (
			.iCLOCK     (iCLOCK),
			.inRESET    (inRESET),
			.way_bus    (way_bus),
			.way_id_hot (way_bus.fill_way[g]),
			.hit        (way_hit[g]),
			.line_valid (way_valid[g]),
			.word       (way_word[g])
		);
	end

	dcache_way_select #(
		.NUM_WAYS (NUM_WAYS)
	) u_way_select (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.way_hit   (way_hit),
		.way_valid (way_valid),
		.way_word  (way_word),
		.hit       (sel_hit),
		.hit_word  (sel_word),
		.victim    (sel_victim)
	);

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
// Directed testbench for the L1 data cache with memory and IO models; top module of the simulation
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int NUM_WAYS   = 4;
	localparam int NUM_SETS   = 16;
	localparam int LINE_BEATS = 8;
	localparam int LINE_BYTES = LINE_BEATS * 8;
	// Distance between two lines of the same set
	localparam int SET_STRIDE = NUM_SETS * LINE_BYTES;

	localparam logic [31:0] SEED    = 32'hc33b;
	localparam addr_t       IO_BASE = 32'h8000_0000;
	localparam word_t       IO_KEY  = 32'h5a5a_c3c3;

	// Roughly 20 accesses and none of them near 100 cycles
	localparam int ACCESS_COUNT  = 20;
	localparam int ACCESS_CYCLES = 100;
	localparam int MAX_CYCLES    = ACCESS_COUNT * ACCESS_CYCLES;

	logic  iCLOCK = 1'b0;
	logic  inRESET = 1'b0;
	logic  iosr_valid = 1'b0;
	addr_t iosr = '0;
	logic  ldst_req_valid = 1'b0;
	logic  ldst_rw = 1'b0;
	mask_t ldst_mask = '0;
	addr_t ldst_addr = '0;
	word_t ldst_data = '0;
	logic  mem_req_ready = 1'b0;
	logic  mem_rsp_valid = 1'b0;
	beat_t mem_rsp_data = '0;
	logic  io_req_ready = 1'b0;
	logic  io_rsp_valid = 1'b0;
	word_t io_rsp_data = '0;

	logic  ldst_req_ready;
	logic  ldst_rsp_valid;
	word_t ldst_rsp_data;
	logic  mem_req_valid;
	logic  mem_req_rw;
	addr_t mem_req_addr;
	mask_t mem_req_mask;
	word_t mem_req_data;
	logic  io_req_valid;
	logic  io_req_rw;
	addr_t io_req_addr;
	mask_t io_req_mask;
	word_t io_req_data;

	// Model state and bookkeeping
	beat_t       mem [addr_t];
	logic [31:0] mem_rng = SEED;
	logic [31:0] io_rng = SEED ^ 32'h1f2e_3d4c;
	int          mem_reads = 0;
	int          mem_writes = 0;
	addr_t       last_fill_addr = '0;
	addr_t       fill_addr = '0;
	int          beats_left = 0;
	int          io_reqs = 0;
	logic        io_last_rw = 1'b0;
	addr_t       io_last_addr = '0;
	mask_t       io_last_mask = '0;
	word_t       io_last_data = '0;
	logic        io_pending = 1'b0;
	word_t       io_resp = '0;

	int          cycle_cnt = 0;
	int          chk_cnt = 0;
	int          err_cnt = 0;
	int          test_cnt = 0;
	int          test_err_base = 0;
	string       cur_test = "";

	dcache_top #(
		.NUM_WAYS   (NUM_WAYS),
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) DUT (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.iosr_valid     (iosr_valid),
		.iosr           (iosr),
		.ldst_req_valid (ldst_req_valid),
		.ldst_req_ready (ldst_req_ready),
		.ldst_rw        (ldst_rw),
		.ldst_mask      (ldst_mask),
		.ldst_addr      (ldst_addr),
		.ldst_data      (ldst_data),
		.ldst_rsp_valid (ldst_rsp_valid),
		.ldst_rsp_data  (ldst_rsp_data),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_rw     (mem_req_rw),
		.mem_req_addr   (mem_req_addr),
		.mem_req_mask   (mem_req_mask),
		.mem_req_data   (mem_req_data),
		.mem_rsp_valid  (mem_rsp_valid),
		.mem_rsp_data   (mem_rsp_data),
		.io_req_valid   (io_req_valid),
		.io_req_ready   (io_req_ready),
		.io_req_rw      (io_req_rw),
		.io_req_addr    (io_req_addr),
		.io_req_mask    (io_req_mask),
		.io_req_data    (io_req_data),
		.io_rsp_valid   (io_rsp_valid),
		.io_rsp_data    (io_rsp_data)
	);

	always #20 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Untouched memory content hashed from the full beat address
	function automatic beat_t init_beat(input addr_t key);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = xorshift(SEED ^ key);
		hi = xorshift(lo ^ key ^ 32'h9e37_79b9);
		return {hi, lo};
	endfunction

	function automatic beat_t mem_read_beat(input addr_t a);
		addr_t key;
		key = {a[ADDR_W-1:3], 3'b000};
		if (mem.exists(key)) begin
			return mem[key];
		end
		return init_beat(key);
	endfunction

	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input mask_t m);
		word_t res;
		res = old_w;
		for (int b = 0; b < WORD_W / 8; b++) begin
			if (m[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// Word lane 0 is the low half of a beat
	function automatic word_t expected_word(input addr_t a);
		beat_t beat;
		beat = mem_read_beat(a);
		return a[2] ? beat[63:32] : beat[31:0];
	endfunction

	function automatic void mem_write_word(input addr_t a, input mask_t m, input word_t d);
		addr_t key;
		beat_t beat;
		key  = {a[ADDR_W-1:3], 3'b000};
		beat = mem_read_beat(a);
		if (a[2]) begin
			beat[63:32] = merge_bytes(beat[63:32], d, m);
		end else begin
			beat[31:0] = merge_bytes(beat[31:0], d, m);
		end
		mem[key] = beat;
	endfunction

	// Memory with random ready and gaps between refill beats
	always @(posedge iCLOCK) begin
		mem_rng = xorshift(mem_rng);
		if (mem_req_valid && mem_req_ready) begin
			if (mem_req_rw) begin
				mem_reads++;
				last_fill_addr = mem_req_addr;
				fill_addr      = mem_req_addr;
				beats_left     = LINE_BEATS;
			end else begin
				mem_writes++;
				mem_write_word(mem_req_addr, mem_req_mask, mem_req_data);
			end
		end
		mem_req_ready <= mem_rng[0] | mem_rng[1];
		if (beats_left > 0 && (mem_rng[2] | mem_rng[3])) begin
			mem_rsp_valid <= 1'b1;
			mem_rsp_data  <= mem_read_beat(fill_addr);
			fill_addr  = fill_addr + 8;
			beats_left = beats_left - 1;
		end else begin
			mem_rsp_valid <= 1'b0;
		end
	end

	// IO port answers one cycle after each transfer
	always @(posedge iCLOCK) begin
		io_rng = xorshift(io_rng);
		io_rsp_valid <= 1'b0;
		if (io_pending) begin
			io_rsp_valid <= 1'b1;
			io_rsp_data  <= io_resp;
			io_pending = 1'b0;
		end
		if (io_req_valid && io_req_ready) begin
			io_reqs++;
			io_last_rw   = io_req_rw;
			io_last_addr = io_req_addr;
			io_last_mask = io_req_mask;
			io_last_data = io_req_data;
			io_resp      = io_req_addr ^ IO_KEY;
			io_pending   = 1'b1;
		end
		io_req_ready <= io_rng[0];
	end

	task automatic report_failure(input string what);
		err_cnt++;
		$display("error in %s: %s", cur_test, what);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input mask_t exp, input mask_t act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test      = name;
		test_err_base = err_cnt;
		test_cnt++;
	endtask

	task automatic report_test();
		if (err_cnt == test_err_base) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, err_cnt - test_err_base);
		end
	endtask

	// One request with lat counting cycles from the accepting edge to the response
	task automatic access(input logic rw, input addr_t addr, input mask_t mask, input word_t data,
			output word_t rsp, output int lat);
		@(posedge iCLOCK);
		ldst_req_valid <= 1'b1;
		ldst_rw        <= rw;
		ldst_addr      <= addr;
		ldst_mask      <= mask;
		ldst_data      <= data;
		@(negedge iCLOCK);
		while (!ldst_req_ready) begin
			@(negedge iCLOCK);
		end
		@(posedge iCLOCK);
		ldst_req_valid <= 1'b0;
		lat = 0;
		do begin
			@(negedge iCLOCK);
			lat++;
		end while (!ldst_rsp_valid);
		rsp = ldst_rsp_data;
	endtask

	task automatic base_gate();
		int early;
		early = 0;
		start_test("base_gate");
		repeat (10) begin
			@(negedge iCLOCK);
			if (ldst_req_ready) begin
				early++;
			end
		end
		if (early != 0) begin
			report_failure("ldst_req_ready rose before the IO base was loaded");
		end
		@(posedge iCLOCK);
		iosr_valid <= 1'b1;
		iosr       <= IO_BASE;
		@(posedge iCLOCK);
		iosr_valid <= 1'b0;
		@(negedge iCLOCK);
		if (!ldst_req_ready) begin
			report_failure("ldst_req_ready stayed low after the IO base was loaded");
		end
		report_test();
	endtask

	task automatic read_miss_then_hit();
		addr_t a;
		word_t rsp;
		int    lat;
		int    reads0;
		a = 32'h0000_1234;
		start_test("read_miss_then_hit");
		reads0 = mem_reads;
		access(1'b1, a, 4'hf, '0, rsp, lat);
		check_word(cur_test, expected_word(a), rsp);
		if (mem_reads - reads0 != 1) begin
			report_failure("a read miss did not issue exactly one memory read");
		end
		check_addr(cur_test, a & ~addr_t'(LINE_BYTES - 1), last_fill_addr);
		reads0 = mem_reads;
		access(1'b1, a + 8, 4'hf, '0, rsp, lat);
		check_word(cur_test, expected_word(a + 8), rsp);
		if (mem_reads != reads0) begin
			report_failure("a read of a cached line went to memory");
		end
		if (lat != 1) begin
			report_failure($sformatf("hit answered after %0d cycles instead of 1", lat));
		end
		report_test();
	endtask

	task automatic write_through();
		addr_t a;
		word_t merged;
		word_t rsp;
		int    lat;
		int    reads0;
		int    writes0;
		a = 32'h0000_1238;
		start_test("write_through");
		merged  = merge_bytes(expected_word(a), 32'hdead_beef, 4'b0101);
		writes0 = mem_writes;
		access(1'b0, a, 4'b0101, 32'hdead_beef, rsp, lat);
		if (mem_writes - writes0 != 1) begin
			report_failure("a write did not reach memory exactly once");
		end
		check_word(cur_test, merged, expected_word(a));
		reads0 = mem_reads;
		access(1'b1, a, 4'hf, '0, rsp, lat);
		check_word(cur_test, merged, rsp);
		if (mem_reads != reads0) begin
			report_failure("the read after a write hit caused a refill");
		end
		report_test();
	endtask

	task automatic io_routing();
		word_t rsp;
		int    lat;
		int    reads0;
		int    writes0;
		int    io0;
		start_test("io_routing");
		reads0  = mem_reads;
		writes0 = mem_writes;
		io0     = io_reqs;
		access(1'b1, IO_BASE + 32'h40, 4'hf, '0, rsp, lat);
		check_addr(cur_test, 32'h40, io_last_addr);
		check_word(cur_test, 32'h40 ^ IO_KEY, rsp);
		if (io_last_rw !== 1'b1) begin
			report_failure("IO read arrived as a write");
		end
		access(1'b0, IO_BASE + 32'h100, 4'b1100, 32'h1234_5678, rsp, lat);
		check_addr(cur_test, 32'h100, io_last_addr);
		check_word(cur_test, 32'h1234_5678, io_last_data);
		check_mask(cur_test, 4'b1100, io_last_mask);
		if (io_last_rw !== 1'b0) begin
			report_failure("IO write arrived as a read");
		end
		if (io_reqs - io0 != 2) begin
			report_failure("two IO accesses did not give exactly two IO transfers");
		end
		if (mem_reads != reads0 || mem_writes != writes0) begin
			report_failure("an IO access issued a memory request");
		end
		report_test();
	endtask

	task automatic set_conflict();
		addr_t base;
		addr_t a;
		word_t rsp;
		int    lat;
		int    reads0;
		base = 32'h0000_2084;
		start_test("set_conflict");
		reads0 = mem_reads;
		// Two passes over one more line than there are ways
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i <= NUM_WAYS; i++) begin
				a = base + addr_t'(i * SET_STRIDE);
				access(1'b1, a, 4'hf, '0, rsp, lat);
				check_word(cur_test, expected_word(a), rsp);
			end
		end
		if (mem_reads - reads0 < NUM_WAYS + 2) begin
			report_failure($sformatf("only %0d refills, so no line was evicted",
				mem_reads - reads0));
		end
		report_test();
	endtask

	initial begin : watchdog
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge iCLOCK);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, a request got no response", cycle_cnt);
		$display("Test failed");
		$finish;
	end

	initial begin
		repeat (2) @(posedge iCLOCK);
		inRESET <= 1'b1;
		base_gate();
		read_miss_then_hit();
		write_through();
		io_routing();
		set_conflict();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
design/dcache_pkg.sv
design/dcache_way_if.sv
design/dcache_way.sv
design/dcache_way_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_way_if.sv
  - design/dcache_way.sv
  - design/dcache_way_select.sv
  - design/dcache_ctrl.sv
  - design/dcache_top.sv
  - target: simulation
    files:
      - verif/tb_dcache.sv
